// File: rtl/alut_defines.svh
// alut sizes and host register map
// shared by the rtl and the testbench
`ifndef ALUT_DEFINES_SVH
`define ALUT_DEFINES_SVH

`define ALUT_IDX_W      8        // table index, 256 entries
`define ALUT_MAX_IDX    8'hff    // last slot, table walk stops here
`define ALUT_TIME_W     32       // time stamp width
`define ALUT_ENTRY_W    83       // valid + stamp + port + mac

// register offsets on the host bus
`define ALUT_REG_DIV    4'h0
`define ALUT_REG_AGE    4'h1
`define ALUT_REG_CMD    4'h2
`define ALUT_REG_STAT   4'h3
`define ALUT_REG_LST_LO 4'h4
`define ALUT_REG_LST_HI 4'h5
`endif

// File: rtl/alut_pkg.sv
// alut types: table entry layout and the state and command enums
package alut_pkg;

`include "alut_defines.svh"

   // one table slot, msb first
   typedef struct packed {
      logic                    valid;
      logic [`ALUT_TIME_W-1:0] stamp;   // last accessed time
      logic [1:0]              port;
      logic [47:0]             mac;
   } alut_entry_t;

   // host commands, as written to the CMD register
   typedef enum logic [1:0] {
      cmd_none       = 2'b00,
      cmd_rsvd       = 2'b01,
      cmd_inval_aged = 2'b10,
      cmd_inval_all  = 2'b11
   } alut_cmd_e;

   typedef enum logic [2:0] {
      age_idle          = 3'b000,
      age_inval_aged_rd = 3'b001,
      age_inval_aged_wr = 3'b010,
      age_inval_all     = 3'b011,
      age_chk           = 3'b100
   } age_state_e;

   typedef enum logic [1:0] {
      add_idle     = 2'b00,
      add_wait_age = 2'b01,
      add_learn_wr = 2'b10,
      add_look_chk = 2'b11
   } addr_state_e;

endpackage

// File: rtl/alut_age_checker.sv
// alut age checker: time base, single age checks for the address checker
// and table walks that clear aged or all entries
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_age_checker
   import alut_pkg::*;
(
   input  logic                    pclk24,
   input  logic                    n_p_reset24,
   input  alut_cmd_e               command,          // from register block
   input  logic [7:0]              div_clk,          // time tick every div_clk+1 cycles
   input  alut_entry_t             mem_rd_data,
   input  logic                    check_age,        // request from addr checker
   input  logic [`ALUT_TIME_W-1:0] last_accessed,    // stamp to check for addr checker
   input  logic [`ALUT_TIME_W-1:0] best_bfr_age,
   input  logic                    add_check_active,
   output logic [`ALUT_TIME_W-1:0] curr_time,
   output logic [`ALUT_IDX_W-1:0]  mem_addr,
   output logic                    mem_write,        // data is always zero
   output logic [47:0]             lst_inv_mac,
   output logic [1:0]              lst_inv_port,
   output logic                    age_confirmed,    // qualifies age_ok
   output logic                    age_ok,           // high = still in date
   output logic                    inval_in_prog,
   output logic                    age_check_active  // status bit 0
);

   age_state_e              state;
   age_state_e              nxt_state;
   logic [7:0]              clk_div_cnt;
   logic                    tick;
   logic                    walk_start;   // leaving idle for a table walk
   logic                    last_idx;
   logic [`ALUT_TIME_W-1:0] stamp_sel;
   logic [`ALUT_TIME_W-1:0] elapsed;

   // ----------------------------------------
   // divided time base
   // ----------------------------------------
   assign tick = (clk_div_cnt == div_clk);

   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         clk_div_cnt <= 8'd0;
         curr_time   <= '0;
      end
      else if (tick)
      begin
         clk_div_cnt <= 8'd0;
         curr_time   <= curr_time + 1'b1;   // free running, wraps
      end
      else
         clk_div_cnt <= clk_div_cnt + 1'b1;
   end

   // ----------------------------------------
   // state machine
   // ----------------------------------------
   assign last_idx = (mem_addr == `ALUT_MAX_IDX);

   always_comb
   begin
      nxt_state = state;
      case (state)
         age_idle:
            if (command == cmd_inval_aged)
               nxt_state = age_inval_aged_rd;
            else if (command == cmd_inval_all)
               nxt_state = age_inval_all;
            else if (check_age)
               nxt_state = age_chk;                     // single check for addr checker
         age_inval_aged_rd:
            nxt_state = age_chk;                        // slot read, go judge it
         age_inval_aged_wr:
            nxt_state = last_idx ? age_idle : age_inval_aged_rd;
         age_inval_all:
            nxt_state = last_idx ? age_idle : age_inval_all;
         age_chk:
            if (age_confirmed)
            begin
               if (add_check_active)
                  nxt_state = age_idle;                 // answer delivered
               else if (mem_rd_data.valid && !age_ok)
                  nxt_state = age_inval_aged_wr;        // out of date, clear it
               else if (last_idx)
                  nxt_state = age_idle;                 // walk done
               else
                  nxt_state = age_inval_aged_rd;        // empty or in date, move on
            end
         default:
            nxt_state = age_idle;
      endcase
   end

   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
         state <= age_idle;
      else
         state <= nxt_state;
   end

   assign age_check_active = (state != age_idle);

   // ----------------------------------------
   // table walk address, writes clear a slot
   // ----------------------------------------
   assign walk_start = (state == age_idle) &&
                       ((nxt_state == age_inval_aged_rd) || (nxt_state == age_inval_all));

   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
         mem_addr <= '0;
      else if (walk_start)
         mem_addr <= '0;                                // every walk starts at slot 0
      else if ((state == age_inval_all) || (nxt_state == age_inval_aged_rd))
         mem_addr <= mem_addr + 1'b1;
   end

   assign mem_write = (state == age_inval_all) || (state == age_inval_aged_wr);

   // set on the first aged clear, dropped when the walk ends
   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
         inval_in_prog <= 1'b0;
      else if (nxt_state == age_idle)
         inval_in_prog <= 1'b0;
      else if (state == age_inval_aged_wr)
         inval_in_prog <= 1'b1;
   end

   // ----------------------------------------
   // age compare
   // ----------------------------------------
   assign stamp_sel = add_check_active ? last_accessed : mem_rd_data.stamp;
   assign elapsed   = curr_time - stamp_sel;   // modulo 2^32, so a wrapped counter still works

   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else if ((state == age_chk) && !age_confirmed)
      begin
         age_confirmed <= 1'b1;                        // one cycle pulse
         age_ok        <= (best_bfr_age > elapsed);
      end
      else
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
   end

   // mac and port of the entry being cleared
   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         lst_inv_mac  <= 48'd0;
         lst_inv_port <= 2'd0;
      end
      else if (state == age_inval_aged_wr)
      begin
         lst_inv_mac  <= mem_rd_data.mac;
         lst_inv_port <= mem_rd_data.port;
      end
   end

endmodule

// File: rtl/alut_addr_checker.sv
// alut address checker: learn and lookup sequencing on the hashed slot
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_addr_checker
   import alut_pkg::*;
(
   input  logic                    pclk24,
   input  logic                    n_p_reset24,
   input  logic                    learn,            // one cycle strobes
   input  logic                    lookup,
   input  logic [47:0]             mac,
   input  logic [1:0]              port,
   input  logic [`ALUT_TIME_W-1:0] curr_time,
   input  alut_cmd_e               command,
   input  logic                    age_check_active,
   input  logic                    age_confirmed,
   input  logic                    age_ok,
   input  alut_entry_t             mem_rd_data,
   output logic [`ALUT_IDX_W-1:0]  mem_addr,
   output logic                    mem_write,
   output alut_entry_t             mem_wr_data,
   output logic                    check_age,
   output logic [`ALUT_TIME_W-1:0] last_accessed,
   output logic                    add_check_active, // table owner flag
   output logic                    lookup_busy,
   output logic                    lookup_done,
   output logic                    lookup_hit,
   output logic [1:0]              lookup_port
);

   addr_state_e state;
   addr_state_e nxt_state;
   logic [47:0] mac_q;
   logic [1:0]  port_q;
   logic        accept;
   logic        entry_match;
   logic        learn_done_q;

   // fold the six mac bytes into an index
   function automatic logic [`ALUT_IDX_W-1:0] mac_hash(input logic [47:0] m);
      return m[47:40] ^ m[39:32] ^ m[31:24] ^ m[23:16] ^ m[15:8] ^ m[7:0];
   endfunction

   // a pending command or a busy age checker holds strobes off
   assign accept = (state == add_idle) && (learn || lookup) &&
                   !age_check_active && (command == cmd_none);
   assign entry_match = mem_rd_data.valid && (mem_rd_data.mac == mac_q);

   always_comb
   begin
      nxt_state = state;
      case (state)
         add_idle:
            if (accept)
               nxt_state = learn ? add_learn_wr : add_look_chk;   // learn wins a tie
         add_learn_wr:
            nxt_state = add_idle;
         add_look_chk:
            nxt_state = entry_match ? add_wait_age : add_idle;
         add_wait_age:
            if (age_confirmed)
               nxt_state = add_idle;
         default:
            nxt_state = add_idle;
      endcase
   end

   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         state        <= add_idle;
         learn_done_q <= 1'b0;
      end
      else
      begin
         state        <= nxt_state;
         learn_done_q <= (state == add_learn_wr);   // done one cycle after the write
      end
   end

   always_ff @(posedge pclk24)
   begin
      if (accept)
      begin
         mac_q  <= mac;
         port_q <= port;
      end
   end

   assign add_check_active = (state != add_idle);
   assign lookup_busy      = add_check_active;

   // table side
   assign mem_addr    = mac_hash(mac_q);
   assign mem_write   = (state == add_learn_wr);
   assign mem_wr_data = {1'b1, curr_time, port_q, mac_q};   // fresh valid entry

   // age request held until answered
   assign check_age     = ((state == add_look_chk) && entry_match) || (state == add_wait_age);
   assign last_accessed = mem_rd_data.stamp;

   assign lookup_done = ((state == add_look_chk) && !entry_match) ||
                        ((state == add_wait_age) && age_confirmed) || learn_done_q;
   assign lookup_hit  = (state == add_wait_age) && age_confirmed && age_ok;
   assign lookup_port = mem_rd_data.port;   // slot still addressed in wait_age

endmodule

// File: rtl/alut_mem.sv
// alut table: 256 entries, combinational read, owner selected write port
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_mem
   import alut_pkg::*;
(
   input  logic                   pclk24,
   input  logic                   n_p_reset24,
   input  logic                   add_check_active,   // addr checker owns the table
   input  logic [`ALUT_IDX_W-1:0] age_addr,
   input  logic                   age_write,
   input  logic [`ALUT_IDX_W-1:0] add_addr,
   input  logic                   add_write,
   input  alut_entry_t            add_wr_data,
   output alut_entry_t            rd_data
);

   logic [`ALUT_ENTRY_W-1:0] tbl [0:`ALUT_MAX_IDX];
   logic [`ALUT_IDX_W-1:0]   addr;
   logic                     wr;
   logic [`ALUT_ENTRY_W-1:0] wr_data;

   // access mux
   assign addr    = add_check_active ? add_addr : age_addr;
   assign wr      = add_check_active ? add_write : age_write;
   assign wr_data = add_check_active ? add_wr_data : '0;   // age checker only clears

   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         for (int i = 0; i <= `ALUT_MAX_IDX; i++)
            tbl[i] <= '0;                                  // empty table
      end
      else if (wr)
         tbl[addr] <= wr_data;
   end

   assign rd_data = alut_entry_t'(tbl[addr]);

endmodule

// File: rtl/alut_regs.sv
// alut host registers: divider, best-before age, command and status
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_regs
   import alut_pkg::*;
(
   input  logic        pclk24,
   input  logic        n_p_reset24,
   input  logic        reg_wr,
   input  logic [3:0]  reg_addr,
   input  logic [31:0] reg_wdata,
   input  logic        add_check_active,
   input  logic        age_check_active,
   input  logic        inval_in_prog,
   input  logic [47:0] lst_inv_mac,
   input  logic [1:0]  lst_inv_port,
   output logic [31:0] reg_rdata,
   output logic [7:0]  div_clk,
   output logic [31:0] best_bfr_age,
   output alut_cmd_e   command
);

   alut_cmd_e cmd_pend;   // written, not yet taken

   always_ff @(posedge pclk24 or negedge n_p_reset24)
   begin
      if (!n_p_reset24)
      begin
         div_clk      <= 8'd0;
         best_bfr_age <= 32'd0;
         cmd_pend     <= cmd_none;
      end
      else
      begin
         if (reg_wr && (reg_addr == `ALUT_REG_DIV))
            div_clk <= reg_wdata[7:0];
         if (reg_wr && (reg_addr == `ALUT_REG_AGE))
            best_bfr_age <= reg_wdata;
         if (reg_wr && (reg_addr == `ALUT_REG_CMD))
            cmd_pend <= alut_cmd_e'(reg_wdata[1:0]);
         else if (!add_check_active)
            cmd_pend <= cmd_none;                // presented this cycle, gone next
      end
   end

   // hold the command back while a learn or lookup runs
   assign command = add_check_active ? cmd_none : cmd_pend;

   // ----------------------------------------
   // read back
   // ----------------------------------------
   always_comb
   begin
      case (reg_addr)
         `ALUT_REG_DIV:    reg_rdata = {24'd0, div_clk};
         `ALUT_REG_AGE:    reg_rdata = best_bfr_age;
         `ALUT_REG_CMD:    reg_rdata = {30'd0, cmd_pend};
         `ALUT_REG_STAT:   reg_rdata = {30'd0, inval_in_prog, age_check_active};
         `ALUT_REG_LST_LO: reg_rdata = lst_inv_mac[31:0];
         `ALUT_REG_LST_HI: reg_rdata = {14'd0, lst_inv_port, lst_inv_mac[47:32]};
         default:          reg_rdata = 32'd0;
      endcase
   end

endmodule

// File: rtl/alut_top.sv
// alut top: register block, both checkers and the table
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_top
   import alut_pkg::*;
(
   input  logic        pclk24,
   input  logic        n_p_reset24,
   // host bus
   input  logic        reg_wr,
   input  logic [3:0]  reg_addr,
   input  logic [31:0] reg_wdata,
   output logic [31:0] reg_rdata,
   // lookup port
   input  logic        learn,
   input  logic        lookup,
   input  logic [47:0] mac,
   input  logic [1:0]  port,
   output logic        lookup_busy,
   output logic        lookup_done,
   output logic        lookup_hit,
   output logic [1:0]  lookup_port
);

   alut_cmd_e               command;
   logic [7:0]              div_clk;
   logic [`ALUT_TIME_W-1:0] best_bfr_age;
   logic [`ALUT_TIME_W-1:0] curr_time;
   logic [`ALUT_TIME_W-1:0] last_accessed;
   logic                    check_age;
   logic                    age_confirmed;
   logic                    age_ok;
   logic                    inval_in_prog;
   logic                    age_check_active;
   logic                    add_check_active;
   logic [47:0]             lst_inv_mac;
   logic [1:0]              lst_inv_port;
   // table ports of each checker
   logic [`ALUT_IDX_W-1:0]  age_mem_addr;
   logic                    age_mem_write;
   logic [`ALUT_IDX_W-1:0]  add_mem_addr;
   logic                    add_mem_write;
   alut_entry_t             add_mem_wr_data;
   alut_entry_t             mem_rd_data;

   alut_regs u_regs (.*);

   alut_age_checker u_age_checker (
      .mem_addr  (age_mem_addr),
      .mem_write (age_mem_write),
      .*
   );

   alut_addr_checker u_addr_checker (
      .mem_addr    (add_mem_addr),
      .mem_write   (add_mem_write),
      .mem_wr_data (add_mem_wr_data),
      .*
   );

   alut_mem u_mem (
      .age_addr    (age_mem_addr),
      .age_write   (age_mem_write),
      .add_addr    (add_mem_addr),
      .add_write   (add_mem_write),
      .add_wr_data (add_mem_wr_data),
      .rd_data     (mem_rd_data),
      .*
   );

endmodule

// File: verif/alut_clk_gen.sv
// alut clock and reset source: 100 ns clock, reset low over 3 rising edges
`timescale 1ns/1ps

module alut_clk_gen
(
   output logic pclk24,
   output logic n_p_reset24
);

   initial
   begin
      pclk24 = 1'b0;
      forever #50 pclk24 = ~pclk24;   // 100 ns period
   end

   initial
   begin
      n_p_reset24 = 1'b0;
      repeat (3) @(posedge pclk24);
      n_p_reset24 <= 1'b1;   // released on the third edge
   end

endmodule

// File: verif/alut_props.sv
// alut age checker assertions: confirm timing, table writes only by the owner,
// nothing left flagged once inactive
`timescale 1ns/1ps

module alut_props
   import alut_pkg::*;
(
   input logic       pclk24,
   input logic       n_p_reset24,
   input age_state_e state,
   input alut_cmd_e  command,
   input logic       check_age,
   input logic       add_check_active,
   input logic       age_confirmed,
   input logic       mem_write,
   input logic       inval_in_prog,
   input logic       age_check_active
);

   int n_fail = 0;   // read by the testbench summary

   // request in idle, age_chk next, a single confirm one cycle later
   a_confirm_timing: assert property (@(posedge pclk24) disable iff (!n_p_reset24)
      (state == age_idle) && check_age && (command == cmd_none)
      |-> ##2 age_confirmed ##1 !age_confirmed)
   else
   begin
      n_fail++;
      $error("age_confirmed not a single pulse two cycles after check_age");
   end

   a_write_owner: assert property (@(posedge pclk24) disable iff (!n_p_reset24)
      mem_write |-> !age_confirmed && !add_check_active)
   else
   begin
      n_fail++;
      $error("table write while judging or while the addr checker owns the table");
   end

   a_idle_inactive: assert property (@(posedge pclk24) disable iff (!n_p_reset24)
      !age_check_active |-> !age_confirmed && !inval_in_prog)
   else
   begin
      n_fail++;
      $error("age checker inactive with a confirm or an invalidation still flagged");
   end

endmodule

bind alut_age_checker alut_props props0 (.*);

// File: verif/alut_checker.sv
// alut reference model: own table and time base, compares lookups and
// register reads, prints one line per test
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_checker
   import alut_pkg::*;
(
   input  logic        pclk24,
   input  logic        n_p_reset24,
   input  logic        reg_wr,
   input  logic [3:0]  reg_addr,
   input  logic [31:0] reg_wdata,
   input  logic [31:0] reg_rdata,
   input  logic        learn,
   input  logic        lookup,
   input  logic [47:0] mac,
   input  logic [1:0]  port,
   input  logic        lookup_busy,
   input  logic        lookup_done,
   input  logic        lookup_hit,
   input  logic [1:0]  lookup_port,
   input  logic        rd_check,      // testbench marks a register read
   input  logic        test_end,
   input  logic [2:0]  test_num,
   output int          n_checks,
   output int          n_errs,
   output int          n_tests_failed
);

   alut_entry_t model_tbl [0:`ALUT_MAX_IDX];
   logic [7:0]  div_val;
   logic [7:0]  div_cnt;
   logic [31:0] age_val;
   logic [31:0] time_now;   // follows curr_time
   logic [31:0] t_next;
   logic [31:0] chk_time;   // time of the age judgement
   logic [47:0] lst_mac;
   logic [1:0]  lst_port;
   logic        op_pend;
   logic        op_learn;
   logic [47:0] op_mac;
   int          op_lat;
   int          test_checks;
   int          test_errs;

   // xor of the six mac bytes
   function automatic logic [7:0] slot_of(input logic [47:0] m);
      logic [7:0] s;
      s = 8'd0;
      for (int b = 0; b < 6; b++)
         s = s ^ m[8*b +: 8];
      return s;
   endfunction

   function automatic logic [31:0] reg_model(input logic [3:0] a);
      case (a)
         `ALUT_REG_DIV:    return {24'd0, div_val};
         `ALUT_REG_AGE:    return age_val;
         `ALUT_REG_STAT:   return 32'd0;   // read only after a walk ends
         `ALUT_REG_LST_LO: return lst_mac[31:0];
         `ALUT_REG_LST_HI: return {14'd0, lst_port, lst_mac[47:32]};
         default:          return 32'd0;
      endcase
   endfunction

   function automatic string test_name(input logic [2:0] n);
      case (n)
         3'd1:    return "learn then hit";
         3'd2:    return "unknown macs miss";
         3'd3:    return "aged lookup";
         3'd4:    return "invalidate all";
         default: return "invalidate aged";
      endcase
   endfunction

   task automatic tally(input bit ok, input string msg);
      test_checks++;
      n_checks++;
      if (!ok)
      begin
         test_errs++;
         n_errs++;
         $display("MISMATCH @ %0t: %s", $time, msg);
      end
   endtask

   // table walk result, judged at command time
   task automatic walk_table(input logic [1:0] cmd);
      for (int i = 0; i <= `ALUT_MAX_IDX; i++)
      begin
         if (cmd == 2'b11)
            model_tbl[i] = '0;
         else if ((cmd == 2'b10) && model_tbl[i].valid &&
                  !(age_val > (t_next - model_tbl[i].stamp)))
         begin
            lst_mac      = model_tbl[i].mac;   // highest index wins
            lst_port     = model_tbl[i].port;
            model_tbl[i] = '0;
         end
      end
   endtask

   always @(posedge pclk24)
   begin
      alut_entry_t ent;
      logic        match;
      logic        hit_exp;
      int          lat_exp;
      if (!n_p_reset24)
      begin
         foreach (model_tbl[i])
            model_tbl[i] = '0;
         div_val  = 8'd0;
         div_cnt  = 8'd0;
         age_val  = 32'd0;
         time_now = 32'd0;
         lst_mac  = 48'd0;
         lst_port = 2'd0;
         op_pend  = 1'b0;
         n_checks = 0;
         n_errs   = 0;
         n_tests_failed = 0;
         test_checks    = 0;
         test_errs      = 0;
      end
      else
      begin
         // ----------------------------------------
         // time base, one step per div_val+1 cycles
         // ----------------------------------------
         if (div_cnt == div_val)
         begin
            div_cnt = 8'd0;
            t_next  = time_now + 32'd1;
         end
         else
         begin
            div_cnt = div_cnt + 8'd1;
            t_next  = time_now;
         end

         if (op_pend)
         begin
            op_lat++;
            if (op_lat == 1)
               chk_time = t_next;                 // age_chk cycle follows
            if (lookup_done)
            begin
               op_pend = 1'b0;
               if (op_learn)
                  tally(op_lat == 2, $sformatf("learn %h done after %0d cycles, expected 2",
                                               op_mac, op_lat));
               else
               begin
                  ent     = model_tbl[slot_of(op_mac)];
                  match   = ent.valid && (ent.mac == op_mac);
                  hit_exp = match && (age_val > (chk_time - ent.stamp));   // wraps mod 2^32
                  lat_exp = match ? 3 : 1;
                  tally(lookup_hit == hit_exp, $sformatf("lookup %h hit %0b, expected %0b",
                                                         op_mac, lookup_hit, hit_exp));
                  if (hit_exp)
                     tally(lookup_port == ent.port,
                           $sformatf("lookup %h port %0d, expected %0d",
                                     op_mac, lookup_port, ent.port));
                  tally(op_lat == lat_exp, $sformatf("lookup %h done after %0d, expected %0d",
                                                     op_mac, op_lat, lat_exp));
               end
            end
            else
               tally(lookup_busy, $sformatf("lookup_busy low while %h is in flight",
                                            op_mac));   // busy until done
         end
         else if (lookup_done)
            tally(1'b0, "lookup_done with no learn or lookup in flight");

         // strobe taken only when nothing is in flight
         if ((learn || lookup) && !op_pend)
         begin
            op_pend  = 1'b1;
            op_learn = learn;
            op_mac   = mac;
            op_lat   = 0;
            if (learn)
               model_tbl[slot_of(mac)] = {1'b1, t_next, port, mac};   // stamped in learn_wr
         end

         if (reg_wr)
         begin
            case (reg_addr)
               `ALUT_REG_DIV: div_val = reg_wdata[7:0];
               `ALUT_REG_AGE: age_val = reg_wdata;
               `ALUT_REG_CMD: walk_table(reg_wdata[1:0]);
               default:       ;
            endcase
         end

         if (rd_check)
            tally(reg_rdata == reg_model(reg_addr),
                  $sformatf("register %0h read %h, expected %h",
                            reg_addr, reg_rdata, reg_model(reg_addr)));

         time_now = t_next;

         if (test_end)
         begin
            if ((test_errs != 0) || (test_checks == 0))
               n_tests_failed++;
            $display("test %0d %s: %0d checks, %0d errors, %s", test_num,
                     test_name(test_num), test_checks, test_errs,
                     ((test_errs != 0) || (test_checks == 0)) ? "fail" : "pass");
            test_checks = 0;
            test_errs   = 0;
         end
      end
   end

endmodule

// File: verif/alut_tb.sv
// alut testbench: random learn and lookup traffic, table walks by host
// command, and the run summary
`timescale 1ns/1ps
`include "alut_defines.svh"

module alut_tb
   import alut_pkg::*;
;

   // cycle budget per test, doubled for the run limit
   localparam int T1_CYC    = 20 * 12 + 20;
   localparam int T2_CYC    = 30 * 6;
   localparam int T3_CYC    = 60 + 4 * 6 + 20;
   localparam int T4_CYC    = 300 + 22 * 6 + 10;
   localparam int T5_CYC    = 2200 + 32 * 6 + 4 * 256 + 40;
   localparam int RUN_LIMIT = 2 * (T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC) + 20;

   logic        pclk24;
   logic        n_p_reset24;
   logic        reg_wr;
   logic [3:0]  reg_addr;
   logic [31:0] reg_wdata;
   logic [31:0] reg_rdata;
   logic        learn;
   logic        lookup;
   logic [47:0] mac;
   logic [1:0]  port;
   logic        lookup_busy;
   logic        lookup_done;
   logic        lookup_hit;
   logic [1:0]  lookup_port;
   logic        rd_check;
   logic        test_end;
   logic [2:0]  test_num;
   int          n_checks;
   int          n_errs;
   int          n_tests_failed;
   int          cycle_cnt;
   logic [31:0] rng_state;
   bit          used [0:255];   // slots taken in the current test

   alut_clk_gen clk0 (.pclk24, .n_p_reset24);
   alut_top     dut0 (.*);
   alut_checker chk0 (.*);

   function logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic logic [47:0] random_mac();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = lcg_next();
      lo = lcg_next();
      return {hi[31:16], lo};
   endfunction

   function automatic logic [7:0] fold_mac(input logic [47:0] m);
      return m[7:0] ^ m[15:8] ^ m[23:16] ^ m[31:24] ^ m[39:32] ^ m[47:40];
   endfunction

   // random mac whose slot is still free in this test
   task automatic fresh_mac(output logic [47:0] m);
      do
         m = random_mac();
      while (used[fold_mac(m)]);
      used[fold_mac(m)] = 1'b1;
   endtask

   task automatic reg_write(input logic [3:0] a, input logic [31:0] d);
      @(posedge pclk24);
      reg_wr    <= 1'b1;
      reg_addr  <= a;
      reg_wdata <= d;
      @(posedge pclk24);
      reg_wr    <= 1'b0;
   endtask

   task automatic reg_check(input logic [3:0] a);
      @(posedge pclk24);
      reg_addr <= a;
      rd_check <= 1'b1;
      @(posedge pclk24);
      rd_check <= 1'b0;
   endtask

   // one learn or lookup, back to idle on lookup_done
   task automatic strobe(input logic is_learn, input logic [47:0] m, input logic [1:0] p);
      @(negedge pclk24);
      while (lookup_busy)
         @(negedge pclk24);
      @(posedge pclk24);
      learn  <= is_learn;
      lookup <= !is_learn;
      mac    <= m;
      port   <= p;
      @(posedge pclk24);
      learn  <= 1'b0;
      lookup <= 1'b0;
      @(negedge pclk24);
      while (!lookup_done)
         @(negedge pclk24);
   endtask

   task automatic learn_new(output logic [47:0] m);
      logic [31:0] r;
      fresh_mac(m);
      r = lcg_next();
      strobe(1'b1, m, r[5:4]);
   endtask

   // command a table walk, status bit 0 rises then falls
   task automatic run_cmd(input alut_cmd_e c);
      reg_write(`ALUT_REG_CMD, {30'd0, c});
      reg_addr <= `ALUT_REG_STAT;
      @(negedge pclk24);
      while (!reg_rdata[0])
         @(negedge pclk24);
      while (reg_rdata[0])
         @(negedge pclk24);
   endtask

   task automatic finish_test(input logic [2:0] n);
      @(posedge pclk24);
      test_end <= 1'b1;
      test_num <= n;
      @(posedge pclk24);
      test_end <= 1'b0;
   endtask

   // ----------------------------------------
   // run limit
   // ----------------------------------------
   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < RUN_LIMIT)
      begin
         @(posedge pclk24);
         cycle_cnt++;
      end
      $display("timeout: run still busy after %0d cycles, a wait on the DUT never ended",
               RUN_LIMIT);
      $display("Test FAILED");
      $finish;
   end

   initial
   begin
      logic [47:0] m;
      logic [47:0] learned [$];
      logic [47:0] aged_set [$];
      int          asrt_fails;
      rng_state = 32'h4b3b0925;
      reg_wr    = 1'b0;
      reg_addr  = 4'd0;
      reg_wdata = 32'd0;
      learn     = 1'b0;
      lookup    = 1'b0;
      mac       = 48'd0;
      port      = 2'd0;
      rd_check  = 1'b0;
      test_end  = 1'b0;
      test_num  = 3'd0;
      @(posedge n_p_reset24);

      // 1: learned macs hit with their port
      foreach (used[i])
         used[i] = 1'b0;
      reg_write(`ALUT_REG_DIV, 32'd0);
      reg_write(`ALUT_REG_AGE, 32'h7fff_ffff);
      repeat (20)
      begin
         learn_new(m);
         learned.push_back(m);
      end
      foreach (learned[i])
         strobe(1'b0, learned[i], 2'd0);
      reg_check(`ALUT_REG_DIV);
      reg_check(`ALUT_REG_AGE);
      finish_test(3'd1);

      // 2: never learned macs miss
      repeat (30)
         strobe(1'b0, random_mac(), 2'd0);
      finish_test(3'd2);

      // 3: stale entry misses, fresh one hits
      reg_write(`ALUT_REG_AGE, 32'd40);
      m = random_mac();
      learned.push_back(m);
      strobe(1'b1, m, 2'd1);
      repeat (60) @(posedge pclk24);
      strobe(1'b0, m, 2'd0);
      m = random_mac();
      learned.push_back(m);
      strobe(1'b1, m, 2'd2);
      strobe(1'b0, m, 2'd0);
      finish_test(3'd3);

      // 4: clear everything
      run_cmd(cmd_inval_all);
      reg_check(`ALUT_REG_STAT);
      foreach (learned[i])
         strobe(1'b0, learned[i], 2'd0);
      finish_test(3'd4);

      // 5: old set ages out, fresh set stays
      foreach (used[i])
         used[i] = 1'b0;
      reg_write(`ALUT_REG_AGE, 32'd2000);
      repeat (8)
      begin
         learn_new(m);
         aged_set.push_back(m);
      end
      repeat (2200) @(posedge pclk24);   // well past the best-before age
      repeat (8)
      begin
         learn_new(m);
         aged_set.push_back(m);
      end
      run_cmd(cmd_inval_aged);
      reg_check(`ALUT_REG_STAT);
      reg_check(`ALUT_REG_LST_LO);
      reg_check(`ALUT_REG_LST_HI);
      foreach (aged_set[i])
         strobe(1'b0, aged_set[i], 2'd0);
      finish_test(3'd5);

      repeat (2) @(posedge pclk24);
      asrt_fails = dut0.u_age_checker.props0.n_fail;
      $display("tests 5, passed %0d, failed %0d, checks %0d, mismatches %0d, assertions %0d",
               5 - n_tests_failed, n_tests_failed, n_checks, n_errs, asrt_fails);
      if ((n_tests_failed == 0) && (n_errs == 0) && (asrt_fails == 0))
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// File: alut.f
+incdir+rtl
rtl/alut_pkg.sv
rtl/alut_age_checker.sv
rtl/alut_addr_checker.sv
rtl/alut_mem.sv
rtl/alut_regs.sv
rtl/alut_top.sv
verif/alut_clk_gen.sv
verif/alut_props.sv
verif/alut_checker.sv
verif/alut_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the alut testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module alut_tb \
   -f alut.f -o alut_sim

out=$(./obj_dir/alut_sim +verilator+error+limit+100 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'Test OK'
